/* Bender.yml */
package:
  name: control_unit

sources:
  - source/cuPkg.sv
  - source/decodeIf.sv
  - source/instrDecoder.sv
  - source/stepSequencer.sv
  - source/controlEncoder.sv
  - source/controlUnit.sv
  - target: test
    files:
      - bench/controlUnitTb.sv

/* bench/controlUnitTb.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnitTb;
    import cuPkg::*;

    localparam int FixedCount = 29;
    localparam int EntryCount = FixedCount + 20;     // 20 random entries follow the table
    localparam int CycleLimit = 8 * EntryCount + 20;  // Longest instruction is 8 cycles

    // Bit or bus source for each sub-field
    localparam int      CompBits [3] = '{compM, compK, compN};
    localparam int      MoveBits [3] = '{wenRp, wenRt, wenC1};
    localparam int      IncBits  [5] = '{incC2, incC3, incRm2, incRk2, incRn2};
    localparam busSelT  LoadSrc  [2] = '{busC1, busC2};
    localparam busSelT  SetSrc   [2] = '{busC1, busDr};
    localparam busSelT  AddSrc   [3] = '{busRt, busRm1, busRm2};
    localparam rstMaskT RstMasks [3] = '{5'b11111, 5'b00010, 5'b00100};  // ALL, N2, K2

    typedef struct packed {
        logic    iRomRead;
        logic    memRead;
        logic    memWrite;
        regMaskT wEn;
        busSelT  busSel;
        incMaskT inc;
        rstMaskT rst;
        compSelT compSel;
        aluOpT   aluOp;
    } ctrlWordT;

    // Columns {z, opcode, sub}
    localparam logic [8:0] FixedTable [FixedCount] = '{
        9'h000, 9'h047, 9'h09f,                          // NOOP, STORE, MUL with a free sub
        9'h110, 9'h010, 9'h111, 9'h011, 9'h112, 9'h012,  // JMP M, K, N with z high and low
        9'h030, 9'h031,                                  // LOAD C1, C2
        9'h060, 9'h061, 9'h062, 9'h070, 9'h071, 9'h072,  // RESET, MOVE
        9'h080, 9'h081, 9'h0a0, 9'h0a1, 9'h0a2,          // SET, ADD
        9'h0b0, 9'h0b1, 9'h0b2, 9'h0b3, 9'h0b4,          // INC
        9'h020, 9'h0b5                                   // Unused opcode and INC sub too large
    };

    logic        Clk = 1'b0;
    logic        arstN;
    logic        z;
    instrT       regIr;
    logic        iRomRead;
    logic        memRead;
    logic        memWrite;
    regMaskT     wEn;
    busSelT      busSel;
    incMaskT     inc;
    rstMaskT     rst;
    compSelT     compSel;
    aluOpT       aluOp;

    instrT       stimInstr [EntryCount];
    logic        stimZ [EntryCount];
    ctrlWordT    expWords [$];
    logic [31:0] lcgState = 32'd28;  // Seed
    int          cycleCount = 0;
    int          curEntry = -1;     // -1 while still in reset
    int          curWord = 0;

    always #50 Clk = ~Clk;

    controlUnit controlUnit_i (
        .Clk      (Clk),
        .arstN    (arstN),
        .z        (z),
        .regIr    (regIr),
        .iRomRead (iRomRead),
        .memRead  (memRead),
        .memWrite (memWrite),
        .wEn      (wEn),
        .busSel   (busSel),
        .inc      (inc),
        .rst      (rst),
        .compSel  (compSel),
        .aluOp    (aluOp)
    );

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: the instruction table did not finish within %0d cycles",
                     CycleLimit);
            $display("SIMULATION FAILED");
            $fatal(1, "Cycle limit reached");
        end
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic isLegal(input logic [3:0] op, input subT sub);
        case (op)
            opNoop, opStore, opMul:        return 1'b1;
            opJmp, opReset, opMove, opAdd: return sub <= 4'd2;
            opLoad, opSet:                 return sub <= 4'd1;
            opInc:                         return sub <= 4'd4;
            default:                       return 1'b0;  // 2, 5 and 12 up
        endcase
    endfunction

    function automatic ctrlWordT regWrite(input int wBit, input busSelT src);
        ctrlWordT w;
        w = '0;
        w.wEn[wBit] = 1'b1;
        w.busSel    = src;
        return w;
    endfunction

    // Expected output words starting with the fetch iRomRead
    function automatic void buildExpected(input instrT instr, input logic zVal);
        logic [3:0] op;
        subT        sub;
        ctrlWordT   w;

        op  = instr[7:4];
        sub = instr[3:0];
        w   = '0;
        w.iRomRead = 1'b1;
        expWords = '{w};
        w = regWrite(wenIr, busIrom);
        w.inc[incPc] = 1'b1;
        expWords.push_back(w);
        expWords.push_back('0);  // Decode
        if (!isLegal(op, sub) || op == opNoop) return;

        w = '0;
        case (op)
            opJmp: begin
                w.compSel[CompBits[sub]] = 1'b1;
                expWords.push_back(w);
                expWords.push_back('0);  // z sampled here
                w = '0;
                w.iRomRead   = !zVal;    // Read the target byte
                w.inc[incPc] = zVal;     // Equal pair skips it
                expWords.push_back(w);
                if (!zVal) begin
                    expWords.push_back(regWrite(wenAr, busIrom));
                    expWords.push_back(regWrite(wenPc, busAr));
                end
            end
            opLoad: begin
                expWords.push_back(regWrite(wenAr, LoadSrc[sub]));
                w.memRead = 1'b1;
                expWords.push_back(w);
                expWords.push_back(regWrite(wenDr, busMem));
            end
            opStore: begin
                expWords.push_back(regWrite(wenDr, busRt));
                expWords.push_back(regWrite(wenAr, busC3));
                w.memWrite = 1'b1;
                w.busSel   = busDr;
                expWords.push_back(w);
            end
            default: begin
                // Single exec word
                case (op)
                    opReset: w.rst = RstMasks[sub];
                    opMove:  w = regWrite(MoveBits[sub], busAc);
                    opSet: begin
                        w = regWrite(wenAc, SetSrc[sub]);
                        w.aluOp[aluSet] = 1'b1;
                    end
                    opMul: begin
                        w = regWrite(wenAc, busRp);
                        w.aluOp[aluMul] = 1'b1;
                    end
                    opAdd: begin
                        w = regWrite(wenAc, AddSrc[sub]);
                        w.aluOp[aluAdd] = 1'b1;
                    end
                    default: w.inc[IncBits[sub]] = 1'b1;  // INC
                endcase
                expWords.push_back(w);
            end
        endcase
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        $display("Fail at %0t: %s is %0h, expected %0h (entry %0d, word %0d)",
                 $time, name, got, want, curEntry, curWord);
        $display("SIMULATION FAILED");
        $fatal(1, "Control word mismatch");
    endtask

    task automatic strobeCheck(input string name, input logic got, input logic want);
        if (got !== want) reportMismatch(name, 32'(got), 32'(want));
    endtask

    task automatic regMaskCheck(input string name, input regMaskT got, input regMaskT want);
        if (got !== want) reportMismatch(name, 32'(got), 32'(want));
    endtask

    task automatic busSelCheck(input string name, input busSelT got, input busSelT want);
        if (got !== want) reportMismatch(name, 32'(got), 32'(want));
    endtask

    task automatic incMaskCheck(input string name, input incMaskT got, input incMaskT want);
        if (got !== want) reportMismatch(name, 32'(got), 32'(want));
    endtask

    task automatic rstMaskCheck(input string name, input rstMaskT got, input rstMaskT want);
        if (got !== want) reportMismatch(name, 32'(got), 32'(want));
    endtask

    task automatic compSelCheck(input string name, input compSelT got, input compSelT want);
        if (got !== want) reportMismatch(name, 32'(got), 32'(want));
    endtask

    task automatic aluOpCheck(input string name, input aluOpT got, input aluOpT want);
        if (got !== want) reportMismatch(name, 32'(got), 32'(want));
    endtask

    task automatic compareWord(input ctrlWordT want);
        strobeCheck("iRomRead", iRomRead, want.iRomRead);
        strobeCheck("memRead", memRead, want.memRead);
        strobeCheck("memWrite", memWrite, want.memWrite);
        regMaskCheck("wEn", wEn, want.wEn);
        busSelCheck("busSel", busSel, want.busSel);
        incMaskCheck("inc", inc, want.inc);
        rstMaskCheck("rst", rst, want.rst);
        compSelCheck("compSel", compSel, want.compSel);
        aluOpCheck("aluOp", aluOp, want.aluOp);
    endtask

    initial begin
        logic [31:0] rnd;

        arstN = 1'b0;
        z     = 1'b0;
        regIr = '0;
        for (int i = 0; i < EntryCount; i++) begin
            if (i < FixedCount) begin
                stimInstr[i] = FixedTable[i][7:0];
                stimZ[i]     = FixedTable[i][8];
            end else begin
                rnd          = nextRandom();
                stimInstr[i] = rnd[23:16];  // Middle byte of the LCG state
                stimZ[i]     = rnd[27];
            end
        end

        repeat (7) @(posedge Clk);
        @(negedge Clk);
        compareWord('0);
        @(posedge Clk);
        arstN <= 1'b1;  // Eighth rising edge
        // One cycle of stepIdle and one for the encoder register
        repeat (2) begin
            @(negedge Clk);
            compareWord('0);
        end

        for (int i = 0; i < EntryCount; i++) begin
            buildExpected(stimInstr[i], stimZ[i]);
            curEntry = i;
            for (int j = 0; j < expWords.size(); j++) begin
                @(posedge Clk);
                if (j == 0) begin
                    regIr <= stimInstr[i];  // Held through decode and jmpCheck
                    z     <= stimZ[i];
                end
                curWord = j;
                @(negedge Clk);
                compareWord(expWords[j]);
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
source/cuPkg.sv
source/decodeIf.sv
source/instrDecoder.sv
source/stepSequencer.sv
source/controlEncoder.sv
source/controlUnit.sv
bench/controlUnitTb.sv

/* source/controlEncoder.sv */
`timescale 1ns/10ps
`default_nettype none

module controlEncoder (
    input  logic           Clk,
    input  logic           arstN,
    input  cuPkg::stepT    step,
    decodeIf.encoder       dec,
    output logic           iRomRead,
    output logic           memRead,
    output logic           memWrite,
    output cuPkg::regMaskT wEn,
    output cuPkg::busSelT  busSel,
    output cuPkg::incMaskT inc,
    output cuPkg::rstMaskT rst,
    output cuPkg::compSelT compSel,
    output cuPkg::aluOpT   aluOp
);
    import cuPkg::*;

    logic    iRomReadNext;
    logic    memReadNext;
    logic    memWriteNext;
    regMaskT wEnNext;
    busSelT  busSelNext;
    incMaskT incNext;
    rstMaskT rstNext;
    compSelT compSelNext;
    aluOpT   aluOpNext;

    always_comb begin
        iRomReadNext = 1'b0;
        memReadNext  = 1'b0;
        memWriteNext = 1'b0;
        wEnNext      = '0;
        busSelNext   = busIrom;
        incNext      = '0;
        rstNext      = '0;
        compSelNext  = '0;
        aluOpNext    = '0;

        case (step)
            fetchRead: iRomReadNext = 1'b1;
            fetchLoad: begin
                wEnNext[wenIr] = 1'b1;
                incNext[incPc] = 1'b1;
            end
            jmpCompare: begin
                case (dec.sub)
                    subT'(0): compSelNext[compM] = 1'b1;
                    subT'(1): compSelNext[compK] = 1'b1;
                    subT'(2): compSelNext[compN] = 1'b1;
                    default:  compSelNext = '0;
                endcase
            end
            jmpSkip: incNext[incPc] = 1'b1;  // Step over the target byte
            jmpRead: iRomReadNext = 1'b1;
            jmpLoadAr: begin
                wEnNext[wenAr] = 1'b1;   // AR <= target from IROM
            end
            jmpLoadPc: begin
                wEnNext[wenPc] = 1'b1;
                busSelNext     = busAr;
            end
            loadAddr: begin
                wEnNext[wenAr] = 1'b1;
                busSelNext     = (dec.sub == subT'(0)) ? busC1 : busC2;
            end
            loadRead: memReadNext = 1'b1;
            loadData: begin
                wEnNext[wenDr] = 1'b1;
                busSelNext     = busMem;
            end
            storeData: begin
                wEnNext[wenDr] = 1'b1;   // DR <= RT
                busSelNext     = busRt;
            end
            storeAddr: begin
                wEnNext[wenAr] = 1'b1;
                busSelNext     = busC3;
            end
            storeWrite: begin
                memWriteNext = 1'b1;
                busSelNext   = busDr;
            end
            exec: begin
                case (dec.opcode)
                    opReset: begin
                        case (dec.sub)
                            subT'(0): rstNext = '1;  // Clear all
                            subT'(1): rstNext[rstRn2] = 1'b1;
                            subT'(2): rstNext[rstRk2] = 1'b1;
                            default:  rstNext = '0;
                        endcase
                    end
                    opMove: begin
                        busSelNext = busAc;
                        case (dec.sub)
                            subT'(0): wEnNext[wenRp] = 1'b1;
                            subT'(1): wEnNext[wenRt] = 1'b1;
                            subT'(2): wEnNext[wenC1] = 1'b1;
                            default:  wEnNext = '0;
                        endcase
                    end
                    opSet: begin
                        wEnNext[wenAc]    = 1'b1;
                        aluOpNext[aluSet] = 1'b1;
                        busSelNext        = (dec.sub == subT'(0)) ? busC1 : busDr;
                    end
                    opMul: begin
                        wEnNext[wenAc]    = 1'b1;  // AC <= RP * AC
                        aluOpNext[aluMul] = 1'b1;
                        busSelNext        = busRp;
                    end
                    opAdd: begin
                        wEnNext[wenAc]    = 1'b1;
                        aluOpNext[aluAdd] = 1'b1;
                        case (dec.sub)
                            subT'(1): busSelNext = busRm1;
                            subT'(2): busSelNext = busRm2;
                            default:  busSelNext = busRt;
                        endcase
                    end
                    opInc: begin
                        case (dec.sub)
                            subT'(0): incNext[incC2]  = 1'b1;
                            subT'(1): incNext[incC3]  = 1'b1;
                            subT'(2): incNext[incRm2] = 1'b1;
                            subT'(3): incNext[incRk2] = 1'b1;
                            subT'(4): incNext[incRn2] = 1'b1;
                            default:  incNext = '0;
                        endcase
                    end
                    default: wEnNext = '0;
                endcase
            end
            default: wEnNext = '0;  // Idle, decode and jmpCheck stay quiet
        endcase
    end

    // Control word lags its step by one cycle
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            iRomRead <= 1'b0;
            memRead  <= 1'b0;
            memWrite <= 1'b0;
            wEn      <= '0;
            busSel   <= busIrom;
            inc      <= '0;
            rst      <= '0;
            compSel  <= '0;
            aluOp    <= '0;
        end else begin
            iRomRead <= iRomReadNext;
            memRead  <= memReadNext;
            memWrite <= memWriteNext;
            wEn      <= wEnNext;
            busSel   <= busSelNext;
            inc      <= incNext;
            rst      <= rstNext;
            compSel  <= compSelNext;
            aluOp    <= aluOpNext;
        end
    end

endmodule

`default_nettype wire

/* source/controlUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
    input  logic           Clk,
    input  logic           arstN,
    input  logic           z,         // Datapath zero flag
    input  cuPkg::instrT   regIr,
    output logic           iRomRead,
    output logic           memRead,
    output logic           memWrite,
    output cuPkg::regMaskT wEn,
    output cuPkg::busSelT  busSel,
    output cuPkg::incMaskT inc,
    output cuPkg::rstMaskT rst,
    output cuPkg::compSelT compSel,
    output cuPkg::aluOpT   aluOp
);
    import cuPkg::*;

    stepT step;

    decodeIf decBus ();

    instrDecoder instrDecoder_i (
        .Clk   (Clk),
        .arstN (arstN),
        .regIr (regIr),
        .dec   (decBus.decoder)
    );

    stepSequencer stepSequencer_i (
        .Clk   (Clk),
        .arstN (arstN),
        .z     (z),
        .dec   (decBus.sequencer),
        .step  (step)
    );

    controlEncoder controlEncoder_i (
        .Clk      (Clk),
        .arstN    (arstN),
        .step     (step),
        .dec      (decBus.encoder),
        .iRomRead (iRomRead),
        .memRead  (memRead),
        .memWrite (memWrite),
        .wEn      (wEn),
        .busSel   (busSel),
        .inc      (inc),
        .rst      (rst),
        .compSel  (compSel),
        .aluOp    (aluOp)
    );

endmodule

`default_nettype wire

/* source/cuPkg.sv */
`default_nettype none

package cuPkg;

    // Instruction byte, opcode in the upper nibble
    localparam int InstrWidth = 8;
    localparam int OpWidth    = 4;
    localparam int SubWidth   = InstrWidth - OpWidth;

    typedef logic [InstrWidth-1:0] instrT;
    typedef logic [SubWidth-1:0]   subT;

    // Codes 2 and 5 stay free, everything else above 11 is illegal
    typedef enum logic [OpWidth-1:0] {
        opNoop  = 4'd0,
        opJmp   = 4'd1,
        opLoad  = 4'd3,
        opStore = 4'd4,
        opReset = 4'd6,
        opMove  = 4'd7,
        opSet   = 4'd8,
        opMul   = 4'd9,
        opAdd   = 4'd10,
        opInc   = 4'd11
    } opcodeT;

    // Register write enables
    localparam int RegCount = 13;
    typedef logic [RegCount-1:0] regMaskT;

    localparam int wenPc  = 12;
    localparam int wenIr  = 11;
    localparam int wenAr  = 10;
    localparam int wenDr  = 9;
    localparam int wenRp  = 8;
    localparam int wenRt  = 7;
    localparam int wenRm1 = 6;
    localparam int wenRk1 = 5;
    localparam int wenRn1 = 4;
    localparam int wenC1  = 3;
    localparam int wenC2  = 2;
    localparam int wenC3  = 1;
    localparam int wenAc  = 0;

    // Datapath bus sources
    typedef enum logic [3:0] {
        busIrom = 4'd0,  busAc  = 4'd1,  busC3  = 4'd2,  busC2  = 4'd3,
        busC1   = 4'd4,  busRn2 = 4'd5,  busRk2 = 4'd6,  busRm2 = 4'd7,
        busRn1  = 4'd8,  busRk1 = 4'd9,  busRm1 = 4'd10, busRt  = 4'd11,
        busRp   = 4'd12, busDr  = 4'd13, busAr  = 4'd14, busMem = 4'd15
    } busSelT;

    localparam int IncCount = 6;
    typedef logic [IncCount-1:0] incMaskT;

    localparam int incPc  = 5;
    localparam int incRm2 = 4;
    localparam int incRk2 = 3;
    localparam int incRn2 = 2;
    localparam int incC2  = 1;
    localparam int incC3  = 0;

    localparam int RstCount = 5;
    typedef logic [RstCount-1:0] rstMaskT;

    localparam int rstRt  = 4;
    localparam int rstRm2 = 3;
    localparam int rstRk2 = 2;
    localparam int rstRn2 = 1;
    localparam int rstAc  = 0;

    // One-hot comparator pair, both muxes share it
    localparam int CompCount = 3;
    typedef logic [CompCount-1:0] compSelT;

    localparam int compM = 2;
    localparam int compK = 1;
    localparam int compN = 0;

    localparam int AluCount = 3;
    typedef logic [AluCount-1:0] aluOpT;

    localparam int aluAdd = 2;
    localparam int aluMul = 1;
    localparam int aluSet = 0;

    typedef enum logic [4:0] {
        stepIdle, fetchRead, fetchLoad, decode, exec,
        jmpCompare, jmpCheck, jmpSkip, jmpRead, jmpLoadAr, jmpLoadPc,
        loadAddr, loadRead, loadData,
        storeData, storeAddr, storeWrite
    } stepT;

endpackage

`default_nettype wire

/* source/decodeIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface decodeIf ();
    import cuPkg::*;

    logic   capture;  // High while the step is decode
    opcodeT opcode;
    subT    sub;
    logic   legal;    // Opcode and sub-field form a known instruction

    modport sequencer (
        output capture,
        input  opcode,
        input  legal
    );

    modport decoder (
        input  capture,
        output opcode,
        output sub,
        output legal
    );

    modport encoder (
        input opcode,
        input sub
    );

endinterface

`default_nettype wire

/* source/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
    input  logic         Clk,
    input  logic         arstN,
    input  cuPkg::instrT regIr,
    decodeIf.decoder     dec
);
    import cuPkg::*;

    opcodeT opIn;
    subT    subIn;
    logic   legalIn;

    assign opIn  = opcodeT'(regIr[InstrWidth-1 -: OpWidth]);
    assign subIn = regIr[SubWidth-1:0];

    // Legality table, sub-field ranges per opcode
    always_comb begin
        case (opIn)
            opNoop:  legalIn = 1'b1;
            opStore: legalIn = 1'b1;
            opMul:   legalIn = 1'b1;  // Sub ignored
            opJmp:   legalIn = (subIn <= subT'(2));  // M, K, N
            opLoad:  legalIn = (subIn <= subT'(1));  // C1, C2
            opReset: legalIn = (subIn <= subT'(2));  // ALL, N2, K2
            opMove:  legalIn = (subIn <= subT'(2));  // RP, RT, C1
            opSet:   legalIn = (subIn <= subT'(1));  // C1, DR
            opAdd:   legalIn = (subIn <= subT'(2));  // RT, RM1, RM2
            opInc:   legalIn = (subIn <= subT'(4));  // C2, C3, M2, K2, N2
            default: legalIn = 1'b0;
        endcase
    end

    // Instruction held until the next decode step
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            dec.opcode <= opNoop;
            dec.sub    <= '0;
            dec.legal  <= 1'b0;
        end else if (dec.capture) begin
            dec.opcode <= opIn;
            dec.sub    <= subIn;
            dec.legal  <= legalIn;
        end
    end

endmodule

`default_nettype wire

/* source/stepSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module stepSequencer (
    input  logic        Clk,
    input  logic        arstN,
    input  logic        z,
    decodeIf.sequencer  dec,
    output cuPkg::stepT step
);
    import cuPkg::*;

    stepT stepQ;     // Registered step
    stepT stepNext;
    logic dispatch;  // First cycle after decode

    assign dec.capture = (step == decode);

    // The decoder registers the opcode at the end of decode, so the branch
    // target is picked in the following cycle from the held fields
    always_comb begin
        step = stepQ;
        if (dispatch) begin
            if (!dec.legal) begin
                step = fetchRead;
            end else begin
                case (dec.opcode)
                    opJmp:   step = jmpCompare;
                    opLoad:  step = loadAddr;
                    opStore: step = storeData;
                    opReset: step = exec;
                    opMove:  step = exec;
                    opSet:   step = exec;
                    opMul:   step = exec;
                    opAdd:   step = exec;
                    opInc:   step = exec;
                    default: step = fetchRead;  // NOOP
                endcase
            end
        end
    end

    always_comb begin
        case (step)
            stepIdle:   stepNext = fetchRead;
            fetchRead:  stepNext = fetchLoad;
            fetchLoad:  stepNext = decode;
            decode:     stepNext = decode;  // Overridden by dispatch
            jmpCompare: stepNext = jmpCheck;
            jmpCheck:   stepNext = z ? jmpSkip : jmpRead;  // Zero means pair equal, no jump
            jmpRead:    stepNext = jmpLoadAr;
            jmpLoadAr:  stepNext = jmpLoadPc;
            loadAddr:   stepNext = loadRead;
            loadRead:   stepNext = loadData;
            storeData:  stepNext = storeAddr;
            storeAddr:  stepNext = storeWrite;

            // exec, jmpSkip, jmpLoadPc, loadData and storeWrite end the instruction
            default:    stepNext = fetchRead;
        endcase
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            stepQ    <= stepIdle;
            dispatch <= 1'b0;
        end else begin
            stepQ    <= stepNext;
            dispatch <= (step == decode);
        end
    end

endmodule

`default_nettype wire
